//--- logic/rs_gf_pkg.sv
/*
  GF(2^8) field package
  field constants, element and antilog table types
  general multiply, antilog table builder, bit count
*/

`default_nettype none

package rs_gf_pkg;

  //--------------------------------------------------
  // field constants
  //--------------------------------------------------

  localparam int gf_m      = 8;    // symbol width
  localparam int gf_irrpol = 285;  // x^8 + x^4 + x^3 + x^2 + 1
  localparam int gf_n_max  = 255;  // multiplicative group order

  typedef logic [gf_m-1:0]        gf_data_t;
  typedef gf_data_t [gf_n_max:0]  gf_rom_t;   // alpha^0 .. alpha^255
  typedef logic [2*gf_m-2:0]      gf_prod_t;  // raw carry-less product

  //--------------------------------------------------
  // functions
  //--------------------------------------------------

  // antilog table, index is the power of alpha
  function automatic gf_rom_t gf_alpha_to(input int irrpol);
    gf_rom_t rom;
    int      acc;
    acc = 1;
    for (int i = 0; i <= gf_n_max; i++) begin
      rom[i] = gf_data_t'(acc);
      acc    = acc << 1;
      if (acc >= (1 << gf_m)) begin
        acc = acc ^ irrpol;  // reduce back into the field
      end
    end
    return rom;
  endfunction

  // shift-and-add product, then fold the high bits
  function automatic gf_data_t gf_mult(input gf_data_t a, input gf_data_t b);
    gf_prod_t prod;
    prod = '0;
    for (int i = 0; i < gf_m; i++) begin
      if (b[i]) begin
        prod = prod ^ (gf_prod_t'(a) << i);
      end
    end
    for (int i = 2*gf_m-2; i >= gf_m; i--) begin
      if (prod[i]) begin
        prod = prod ^ (gf_prod_t'(gf_irrpol) << (i - gf_m));
      end
    end
    return prod[gf_m-1:0];
  endfunction

  // ones in one symbol, 0 to gf_m
  function automatic logic [$clog2(gf_m+1)-1:0] gf_bit_count(input gf_data_t v);
    logic [$clog2(gf_m+1)-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < gf_m; i++) begin
      cnt = cnt + v[i];
    end
    return cnt;
  endfunction

endpackage

`default_nettype wire

//--- logic/rs_chien_pkg.sv
/*
  RS code level package
  check and error limits, locator and omega polynomials
  frame strobes, statistics and RAM pointer types
*/

`default_nettype none

package rs_chien_pkg;

  localparam int rs_check = 30;           // check symbols
  localparam int rs_errs  = rs_check / 2; // correctable symbols, 15

  // locator, element i is coefficient i (0 to 15)
  typedef rs_gf_pkg::gf_data_t [rs_errs:0]   loc_poly_t;
  // error value, element j holds coefficient j+1 (1 to 15)
  typedef rs_gf_pkg::gf_data_t [rs_errs-1:0] omega_poly_t;

  typedef struct packed {
    logic sop;  // first symbol of the frame
    logic val;  // symbol valid
    logic eop;  // last data symbol, n - rs_check
    logic eof;  // last symbol, n
  } frame_strb_t;

  typedef logic [4:0] err_cnt_t;  // up to 15 symbols, room for n zeros mod 32
  typedef logic [7:0] bit_cnt_t;  // 15 * 8 max

  typedef struct packed {
    logic     decfail;
    err_cnt_t num_err_sym;
    bit_cnt_t num_err_bit;
  } rs_stat_t;

  typedef logic [1:0] ram_ptr_t;  // codeword buffer select

endpackage

`default_nettype wire

//--- logic/rs_chien_ctrl.sv
/*
  Chien search control
  search down-counter and strobe acceptance, frame strobe delay line
  codeword RAM address counter and buffer pointer latch
*/

`timescale 1ns/1ps
`default_nettype none

module rs_chien_ctrl #(
  parameter int n = 240  // shortened code length
) (
  input  wire                        iclk,
  input  wire                        ireset,
  input  wire                        loc_val,
  input  wire rs_chien_pkg::ram_ptr_t loc_ptr,
  output logic                       start,
  output logic                       search,
  output rs_gf_pkg::gf_data_t        ram_addr,
  output rs_chien_pkg::ram_ptr_t     ram_ptr,
  output rs_chien_pkg::frame_strb_t  strb_dly
);

  import rs_gf_pkg::*;
  import rs_chien_pkg::*;

  localparam int line_depth = 5;  // strobe lead over the corrected symbol

  gf_data_t    cnt;      // remaining search cycles
  gf_data_t    cnt_nxt;
  frame_strb_t line_in;  // frame view of the next cycle
  frame_strb_t strb_line [line_depth];

  //--------------------------------------------------
  // search counter
  //--------------------------------------------------

  assign search = (cnt != '0);
  assign start  = loc_val & (cnt <= gf_data_t'(1));  // idle or last search cycle

  always_comb begin
    if (start) begin
      cnt_nxt = gf_data_t'(n);
    end else if (search) begin
      cnt_nxt = cnt - 1'b1;
    end else begin
      cnt_nxt = cnt;
    end
  end

  // strobes built one cycle ahead of search, so the line lands at s+5
  always_comb begin
    line_in.sop = start;
    line_in.val = (cnt_nxt != '0);
    line_in.eop = (cnt_nxt == gf_data_t'(rs_check + 1));
    line_in.eof = (cnt_nxt == gf_data_t'(1));
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt       <= '0;
      strb_line <= '{default: '0};
      ram_addr  <= '0;
      ram_ptr   <= '0;
    end else begin
      cnt          <= cnt_nxt;
      strb_line[0] <= line_in;
      for (int i = 1; i < line_depth; i++) begin
        strb_line[i] <= strb_line[i-1];
      end
      // address generator, one symbol per search cycle
      if (start) begin
        ram_addr <= '0;
        ram_ptr  <= loc_ptr;  // buffer of the accepted frame
      end else if (search) begin
        ram_addr <= ram_addr + 1'b1;
      end
    end
  end

  assign strb_dly = strb_line[line_depth-1];

endmodule

`default_nettype wire

//--- logic/rs_poly_eval.sv
/*
  stepped polynomial evaluator for the Chien search
  one register per coefficient, all terms and odd terms summed
*/

`timescale 1ns/1ps
`default_nettype none

module rs_poly_eval #(
  parameter int  n         = 240,                          // shortened code length
  parameter int  num_terms = rs_chien_pkg::rs_errs + 1,
  parameter type poly_t    = rs_chien_pkg::loc_poly_t
) (
  input  wire                 iclk,
  input  wire                 start,
  input  wire                 search,
  input  wire poly_t          coef,
  output rs_gf_pkg::gf_data_t sum,
  output rs_gf_pkg::gf_data_t odd_sum
);

  import rs_gf_pkg::*;

  localparam gf_rom_t alpha_rom = gf_alpha_to(gf_irrpol);
  localparam int      skip_pow  = gf_n_max + 1 - n;  // first root is alpha^(256-n)

  gf_data_t term [num_terms];  // coef[i] * x^i at the current root
  gf_data_t sum_nxt;
  gf_data_t odd_nxt;

  //--------------------------------------------------
  // term registers
  //--------------------------------------------------

  always_ff @(posedge iclk) begin
    if (start) begin
      // jump over the roots cut away by shortening
      for (int i = 0; i < num_terms; i++) begin
        term[i] <= gf_mult(coef[i], alpha_rom[(i * skip_pow) % gf_n_max]);
      end
    end else if (search) begin
      for (int i = 0; i < num_terms; i++) begin
        term[i] <= gf_mult(term[i], alpha_rom[i % gf_n_max]);  // next root
      end
    end
  end

  //--------------------------------------------------
  // sums
  //--------------------------------------------------

  always_comb begin
    sum_nxt = '0;
    odd_nxt = '0;
    for (int i = 0; i < num_terms; i++) begin
      sum_nxt = sum_nxt ^ term[i];
      if (i % 2 == 1) begin
        odd_nxt = odd_nxt ^ term[i];  // locator derivative part
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (search) begin
      sum     <= sum_nxt;
      odd_sum <= odd_nxt;
    end
  end

endmodule

`default_nettype wire

//--- logic/rs_gf_div.sv
/*
  pipelined GF(2^8) divider, three cycles of latency
  log of divisor, inverse from antilog table, multiply
*/

`timescale 1ns/1ps
`default_nettype none

module rs_gf_div (
  input  wire                      iclk,
  input  wire rs_gf_pkg::gf_data_t dividend,
  input  wire rs_gf_pkg::gf_data_t divisor,
  output rs_gf_pkg::gf_data_t      quotient
);

  import rs_gf_pkg::*;

  // log table from the antilog table, log of zero left at 0
  function automatic gf_rom_t gf_log_of(input gf_rom_t alpha);
    gf_rom_t lg;
    lg = '0;
    for (int i = 0; i < gf_n_max; i++) begin
      lg[alpha[i]] = gf_data_t'(i);
    end
    return lg;
  endfunction

  localparam gf_rom_t alpha_rom = gf_alpha_to(gf_irrpol);
  localparam gf_rom_t log_rom   = gf_log_of(alpha_rom);

  gf_data_t dvd_s1;
  gf_data_t dvd_s2;
  gf_data_t log_s1;   // log of divisor
  logic     zero_s1;  // divide by zero
  gf_data_t inv_s2;   // 1 / divisor

  always_ff @(posedge iclk) begin
    // stage 1
    log_s1  <= log_rom[divisor];
    zero_s1 <= (divisor == '0);
    dvd_s1  <= dividend;
    // stage 2, alpha^(255 - log), index stays in 1..255
    inv_s2  <= zero_s1 ? '0 : alpha_rom[gf_n_max - int'(log_s1)];
    dvd_s2  <= dvd_s1;
    // stage 3
    quotient <= gf_mult(dvd_s2, inv_s2);  // zero divisor gives zero
  end

endmodule

`default_nettype wire

//--- logic/rs_err_correct.sv
/*
  error correction and frame statistics
  zero flag and RAM data alignment to the divider, XOR correction
  symbol and bit counters, decode failure decision, output registers
*/

`timescale 1ns/1ps
`default_nettype none

module rs_err_correct (
  input  wire                              iclk,
  input  wire                              ireset,
  input  wire                              start,
  input  wire                              loc_decfail,
  input  wire rs_chien_pkg::loc_poly_t     loc_poly,
  input  wire rs_chien_pkg::frame_strb_t   strb_dly,
  input  wire rs_gf_pkg::gf_data_t         loc_sum,
  input  wire rs_gf_pkg::gf_data_t         err_val,
  input  wire rs_gf_pkg::gf_data_t         ram_data,
  output rs_chien_pkg::frame_strb_t        out_strb,
  output rs_gf_pkg::gf_data_t              out_dat,
  output rs_chien_pkg::rs_stat_t           stat
);

  import rs_gf_pkg::*;
  import rs_chien_pkg::*;

  logic [2:0]                zero_dly;  // locator root flag, matches divider latency
  gf_data_t                  ram_d1;    // RAM data lands at s+3
  gf_data_t                  ram_d2;
  logic                      err_hit;
  gf_data_t                  err_sym;
  logic [$clog2(gf_m+1)-1:0] err_bits;
  err_cnt_t                  sym_cnt;
  bit_cnt_t                  bit_cnt;
  logic [rs_errs:1]          nz_tick;   // locator pattern, latched at start
  logic                      dfail_tick;
  err_cnt_t                  deg_tack;  // degree held for the frame on the output
  logic                      dfail_tack;

  // highest nonzero locator coefficient
  function automatic err_cnt_t loc_deg(input logic [rs_errs:1] nz);
    err_cnt_t d;
    d = '0;
    for (int i = 1; i <= rs_errs; i++) begin
      if (nz[i]) begin
        d = err_cnt_t'(i);
      end
    end
    return d;
  endfunction

  //--------------------------------------------------
  // alignment and correction
  //--------------------------------------------------

  assign err_hit  = zero_dly[2];
  assign err_sym  = err_hit ? err_val : '0;  // Forney value only at a root
  assign err_bits = gf_bit_count(err_sym);

  always_ff @(posedge iclk) begin
    zero_dly <= {zero_dly[1:0], (loc_sum == '0)};
    ram_d1   <= ram_data;
    ram_d2   <= ram_d1;
    out_dat  <= ram_d2 ^ err_sym;
  end

  //--------------------------------------------------
  // statistics
  //--------------------------------------------------

  always_ff @(posedge iclk) begin
    if (start) begin
      for (int i = 1; i <= rs_errs; i++) begin
        nz_tick[i] <= (loc_poly[i] != '0);
      end
      dfail_tick <= loc_decfail;
    end
    // second copy, a back-to-back start overwrites the first one early
    if (strb_dly.sop) begin
      deg_tack   <= loc_deg(nz_tick);
      dfail_tack <= dfail_tick;
    end
    if (strb_dly.val) begin
      sym_cnt <= strb_dly.sop ? err_cnt_t'(err_hit)  : sym_cnt + err_cnt_t'(err_hit);
      bit_cnt <= strb_dly.sop ? bit_cnt_t'(err_bits) : bit_cnt + bit_cnt_t'(err_bits);
    end
    // counters are complete one cycle after the last symbol
    if (out_strb.eof) begin
      stat.decfail     <= (sym_cnt != deg_tack) | dfail_tack;
      stat.num_err_sym <= sym_cnt;
      stat.num_err_bit <= bit_cnt;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_strb <= '0;
    end else begin
      out_strb <= strb_dly;  // in step with out_dat
    end
  end

endmodule

`default_nettype wire

//--- logic/rs_chien_search.sv
/*
  RS Chien search and Forney error value stage, top level
  control, locator and omega evaluators, divider, correction
*/

`timescale 1ns/1ps
`default_nettype none

module rs_chien_search #(
  parameter int n = 240  // shortened code length, 31 to 255
) (
  input  wire                              iclk,
  input  wire                              ireset,
  input  wire                              loc_val,
  input  wire rs_chien_pkg::loc_poly_t     loc_poly,
  input  wire rs_chien_pkg::omega_poly_t   omega_poly,
  input  wire                              loc_decfail,
  input  wire rs_chien_pkg::ram_ptr_t      loc_ptr,
  input  wire rs_gf_pkg::gf_data_t         ram_data,
  output rs_gf_pkg::gf_data_t              ram_addr,
  output rs_chien_pkg::ram_ptr_t           ram_ptr,
  output rs_chien_pkg::frame_strb_t        out_strb,
  output rs_gf_pkg::gf_data_t              out_dat,
  output rs_chien_pkg::rs_stat_t           stat
);

  import rs_gf_pkg::*;
  import rs_chien_pkg::*;

  logic        start;
  logic        search;
  frame_strb_t strb_dly;
  gf_data_t    loc_sum;    // locator at the root, s+2 onward
  gf_data_t    loc_odd;    // odd locator terms, divisor
  gf_data_t    omega_sum;  // error value polynomial, dividend
  gf_data_t    err_val;    // quotient, s+5 onward

  rs_chien_ctrl #(.n(n)) u_ctrl (
    .iclk     (iclk),
    .ireset   (ireset),
    .loc_val  (loc_val),
    .loc_ptr  (loc_ptr),
    .start    (start),
    .search   (search),
    .ram_addr (ram_addr),
    .ram_ptr  (ram_ptr),
    .strb_dly (strb_dly)
  );

  rs_poly_eval #(.n(n), .num_terms(rs_errs + 1), .poly_t(loc_poly_t)) u_loc (
    .iclk    (iclk),
    .start   (start),
    .search  (search),
    .coef    (loc_poly),
    .sum     (loc_sum),
    .odd_sum (loc_odd)
  );

  rs_poly_eval #(.n(n), .num_terms(rs_errs), .poly_t(omega_poly_t)) u_omega (
    .iclk    (iclk),
    .start   (start),
    .search  (search),
    .coef    (omega_poly),
    .sum     (omega_sum),
    .odd_sum ()
  );

  rs_gf_div u_div (
    .iclk     (iclk),
    .dividend (omega_sum),
    .divisor  (loc_odd),
    .quotient (err_val)
  );

  rs_err_correct u_corr (
    .iclk        (iclk),
    .ireset      (ireset),
    .start       (start),
    .loc_decfail (loc_decfail),
    .loc_poly    (loc_poly),
    .strb_dly    (strb_dly),
    .loc_sum     (loc_sum),
    .err_val     (err_val),
    .ram_data    (ram_data),
    .out_strb    (out_strb),
    .out_dat     (out_dat),
    .stat        (stat)
  );

endmodule

`default_nettype wire

//--- verif/tb_rs_model.svh
/*
  reference model for the Chien search testbench
  GF(2^8) log tables, error value by the root rule
  expected symbol and frame statistics, compare tasks
*/

`ifndef tb_rs_model_svh
`define tb_rs_model_svh

gf_data_t ref_exp [255];  // alpha^i
int       ref_log [256];  // log of a nonzero element

task automatic build_field();
  int v;
  v = 1;
  for (int i = 0; i < 255; i++) begin
    ref_exp[i] = gf_data_t'(v);
    ref_log[v] = i;
    v = v << 1;
    if (v > 255) begin
      v = v ^ gf_irrpol;  // fold x^8
    end
  end
endtask

function automatic gf_data_t field_mul(input gf_data_t a, input gf_data_t b);
  gf_data_t p;
  p = '0;
  if (a != '0 && b != '0) begin
    p = ref_exp[(ref_log[a] + ref_log[b]) % 255];
  end
  return p;
endfunction

// zero divisor gives zero
function automatic gf_data_t field_div(input gf_data_t a, input gf_data_t b);
  gf_data_t q;
  q = '0;
  if (a != '0 && b != '0) begin
    q = ref_exp[(ref_log[a] - ref_log[b] + 255) % 255];
  end
  return q;
endfunction

//--------------------------------------------------
// root rule
//--------------------------------------------------

// locator, or its odd terms, at x = alpha^((256-n+k) mod 255)
function automatic gf_data_t loc_at(input int f, input int k, input bit odd_only);
  gf_data_t x;
  gf_data_t xp;
  gf_data_t acc;
  x   = ref_exp[(256 - n + k) % 255];
  xp  = 8'h01;
  acc = '0;
  for (int i = 0; i <= rs_errs; i++) begin
    if (!odd_only || (i % 2 == 1)) begin
      acc = acc ^ field_mul(loc_tab[f][i], xp);
    end
    xp = field_mul(xp, x);
  end
  return acc;
endfunction

// sum of omega_i * x^(i-1)
function automatic gf_data_t omega_at(input int f, input int k);
  gf_data_t x;
  gf_data_t xp;
  gf_data_t acc;
  x   = ref_exp[(256 - n + k) % 255];
  xp  = 8'h01;
  acc = '0;
  for (int j = 0; j < rs_errs; j++) begin
    acc = acc ^ field_mul(om_tab[f][j], xp);
    xp  = field_mul(xp, x);
  end
  return acc;
endfunction

function automatic gf_data_t err_value(input int f, input int k);
  gf_data_t ev;
  ev = '0;
  if (loc_at(f, k, 1'b0) == '0) begin
    ev = field_div(omega_at(f, k), loc_at(f, k, 1'b1));
  end
  return ev;
endfunction

function automatic gf_data_t expected_sym(input int f, input int k);
  return ram_mem[ptr_tab[f]][k] ^ err_value(f, k);
endfunction

function automatic rs_stat_t expected_stat(input int f);
  rs_stat_t st;
  int       zeros;
  int       bits;
  int       deg;
  zeros = 0;
  bits  = 0;
  deg   = 0;
  for (int k = 0; k < n; k++) begin
    if (loc_at(f, k, 1'b0) == '0) begin
      zeros = zeros + 1;
    end
    bits = bits + $countones(err_value(f, k));
  end
  for (int i = 1; i <= rs_errs; i++) begin
    if (loc_tab[f][i] != '0) begin
      deg = i;  // highest nonzero term
    end
  end
  st.decfail     = (zeros != deg) || dfail_tab[f];
  st.num_err_sym = err_cnt_t'(zeros);
  st.num_err_bit = bit_cnt_t'(bits);
  return st;
endfunction

//--------------------------------------------------
// compare tasks
//--------------------------------------------------

task automatic check_dat(input gf_data_t got, input gf_data_t exp, input string name);
  if (got !== exp) begin
    $display("ERR %s got %h expected %h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_strb(input frame_strb_t got, input frame_strb_t exp, input string name);
  if (got !== exp) begin
    $display("ERR %s got %h expected %h (sop val eop eof)", name, got, exp);
    stop_run();
  end
endtask

task automatic check_stat(input rs_stat_t got, input rs_stat_t exp, input string name);
  if (got !== exp) begin
    $display("ERR %s got %h expected %h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_ptr(input ram_ptr_t got, input ram_ptr_t exp, input string name);
  if (got !== exp) begin
    $display("ERR %s got %h expected %h", name, got, exp);
    stop_run();
  end
endtask

`endif

//--- verif/tb_rs_chien.sv
/*
  testbench for the RS Chien search and Forney stage
  clock, reset, frame stimulus, codeword RAM model, compare process, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tb_rs_chien;

  import rs_gf_pkg::*;
  import rs_chien_pkg::*;

  localparam int n              = 240;  // shortened code length
  localparam int clk_period     = 4;
  localparam int reset_cycles   = 5;
  localparam int num_frames     = 7;
  localparam int timeout_cycles = num_frames * (n + 10) + reset_cycles;

  logic        iclk;
  logic        ireset;
  logic        loc_val;
  loc_poly_t   loc_poly;
  omega_poly_t omega_poly;
  logic        loc_decfail;
  ram_ptr_t    loc_ptr;
  gf_data_t    ram_data = '0;
  gf_data_t    ram_addr;
  ram_ptr_t    ram_ptr;
  frame_strb_t out_strb;
  gf_data_t    out_dat;
  rs_stat_t    stat;

  gf_data_t    ram_mem [4][256];  // four codeword buffers
  gf_data_t    ram_rd1 = '0;

  // per-frame stimulus kept for the reference model
  loc_poly_t   loc_tab   [num_frames];
  omega_poly_t om_tab    [num_frames];
  ram_ptr_t    ptr_tab   [num_frames];
  logic        dfail_tab [num_frames];
  int          gap_tab   [num_frames];  // idle cycles before the strobe
  int          start_cyc [num_frames];  // cycle of the accepted loc_val

  integer      seed;
  int          cyc         = 0;
  int          frames_done = 0;

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  `include "tb_rs_model.svh"

  rs_chien_search #(.n(n)) i_dut (
    .iclk        (iclk),
    .ireset      (ireset),
    .loc_val     (loc_val),
    .loc_poly    (loc_poly),
    .omega_poly  (omega_poly),
    .loc_decfail (loc_decfail),
    .loc_ptr     (loc_ptr),
    .ram_data    (ram_data),
    .ram_addr    (ram_addr),
    .ram_ptr     (ram_ptr),
    .out_strb    (out_strb),
    .out_dat     (out_dat),
    .stat        (stat)
  );

  //--------------------------------------------------
  // clock, cycle count, RAM model
  //--------------------------------------------------

  initial begin
    iclk = 1'b0;
    forever #(clk_period / 2) iclk = ~iclk;
  end

  always @(posedge iclk) begin
    cyc      <= cyc + 1;
    ram_rd1  <= ram_mem[ram_ptr][ram_addr];  // two-cycle read pipeline
    ram_data <= ram_rd1;
  end

  //--------------------------------------------------
  // stimulus
  //--------------------------------------------------

  // locator from in-range roots plus roots the shortened search never visits
  task automatic make_frame(input int f, input int n_in, input int n_out,
                            input logic dfail, input ram_ptr_t ptr, input int gap);
    loc_poly_t lp;
    bit        used [n];
    int        k;
    int        e;
    gf_data_t  xr;  // error locator number is the inverse root
    for (int i = 0; i < n; i++) begin
      used[i] = 1'b0;
    end
    lp    = '0;
    lp[0] = 8'h01;
    for (int r = 0; r < n_in + n_out; r++) begin
      if (r < n_in) begin
        k = int'($unsigned($random(seed)) % n);
        while (used[k]) begin
          k = int'($unsigned($random(seed)) % n);  // distinct positions
        end
        used[k] = 1'b1;
        e = (256 - n + k) % 255;
      end else begin
        e = 1 + r - n_in;  // below alpha^(256-n)
      end
      xr = ref_exp[(255 - e) % 255];
      for (int i = rs_errs; i >= 1; i--) begin
        lp[i] = lp[i] ^ field_mul(xr, lp[i-1]);  // times (1 + xr*x)
      end
    end
    loc_tab[f] = lp;
    for (int j = 0; j < rs_errs; j++) begin
      om_tab[f][j] = gf_data_t'($random(seed));
    end
    ptr_tab[f]   = ptr;
    dfail_tab[f] = dfail;
    gap_tab[f]   = gap;
    start_cyc[f] = -100000;  // not sent yet
  endtask

  // strobe at this falling edge, then scramble the sampled inputs
  task automatic send_frame(input int f);
    loc_val      = 1'b1;
    loc_poly     = loc_tab[f];
    omega_poly   = om_tab[f];
    loc_decfail  = dfail_tab[f];
    loc_ptr      = ptr_tab[f];
    start_cyc[f] = cyc;
    @(negedge iclk);
    loc_val      = 1'b0;
    loc_poly     = ~loc_tab[f];
    omega_poly   = ~om_tab[f];
    loc_decfail  = ~dfail_tab[f];
    loc_ptr      = ~ptr_tab[f];
    repeat (n - 1) @(negedge iclk);  // lands on the last search cycle
  endtask

  initial begin : stimulus
    seed        = 32'h6ec9_93b6;
    ireset      = 1'b1;
    loc_val     = 1'b0;
    loc_poly    = '0;
    omega_poly  = '0;
    loc_decfail = 1'b0;
    loc_ptr     = '0;
    build_field();
    for (int b = 0; b < 4; b++) begin
      for (int a = 0; a < 256; a++) begin
        ram_mem[b][a] = gf_data_t'($random(seed));
      end
    end
    make_frame(0, 0,  0, 1'b0, 2'd0, 3);  // clean frame
    make_frame(1, 3,  0, 1'b0, 2'd1, 0);  // back to back from here
    make_frame(2, 15, 0, 1'b0, 2'd2, 0);  // full capacity
    make_frame(3, 8,  0, 1'b0, 2'd3, 7);
    make_frame(4, 4,  1, 1'b0, 2'd0, 0);  // one root outside the range
    make_frame(5, 2,  0, 1'b1, 2'd1, 2);  // upstream failure
    make_frame(6, 1,  0, 1'b0, 2'd2, 0);
    repeat (reset_cycles) @(negedge iclk);
    ireset = 1'b0;
    for (int f = 0; f < num_frames; f++) begin
      repeat (gap_tab[f]) @(negedge iclk);
      send_frame(f);
    end
    wait (frames_done == num_frames);
    repeat (4) @(negedge iclk);  // strobes must stay quiet afterwards
    $display("Testbench passed");
    $finish;
  end

  //--------------------------------------------------
  // compare at mid-cycle
  //--------------------------------------------------

  initial begin : compare
    frame_strb_t exp_strb;
    int          k;
    int          sym_f;
    int          sym_k;
    @(negedge ireset);
    forever begin
      @(negedge iclk);
      exp_strb = '0;
      sym_f    = -1;
      sym_k    = 0;
      for (int f = 0; f < num_frames; f++) begin
        k = cyc - start_cyc[f];
        if (k >= 1 && k <= n) begin  // search cycles
          check_dat(ram_addr, gf_data_t'(k - 1), "ram_addr");
          check_ptr(ram_ptr, ptr_tab[f], "ram_ptr");
        end
        k = k - 6;  // output symbol index
        if (k >= 0 && k < n) begin
          exp_strb.sop = (k == 0);
          exp_strb.val = 1'b1;
          exp_strb.eop = (k == n - rs_check - 1);
          exp_strb.eof = (k == n - 1);
          sym_f        = f;
          sym_k        = k;
        end
        if (k == n) begin  // cycle after eof
          check_stat(stat, expected_stat(f), "stat");
          frames_done = frames_done + 1;
        end
      end
      check_strb(out_strb, exp_strb, "out_strb");
      if (sym_f >= 0) begin
        check_dat(out_dat, expected_sym(sym_f, sym_k), "out_dat");
      end
    end
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("timeout: the frames did not all come out in %0d cycles", timeout_cycles);
    stop_run();
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
logic/rs_gf_pkg.sv
logic/rs_chien_pkg.sv
logic/rs_chien_ctrl.sv
logic/rs_poly_eval.sv
logic/rs_gf_div.sv
logic/rs_err_correct.sv
logic/rs_chien_search.sv
verif/tb_rs_chien.sv

//--- Makefile
# Verilator build and run of the Chien search testbench

VERILATOR  ?= verilator
TOP        := tb_rs_chien
FILELIST   := sim.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation is the result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
